// ==== sources.f ====
+incdir+verilog
verilog/sya_cfg_pkg.sv
verilog/sya_data_pkg.sv
verilog/sya_loop_ctrl.sv
verilog/sya_skew_line.sv
verilog/sya_pe_array.sv
verilog/sya_drain.sv
verilog/sya_top.sv
test/tb_sya_glb.sv
test/tb_sya.sv

// ==== Makefile ====
# Verilator build and run for the systolic array testbench

VERILATOR ?= verilator
TOP       ?= tb_sya
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/tb_sya.sv ====
`include "sya_settings.svh"

module tb_sya
    import sya_cfg_pkg::*;
    import sya_data_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ND = `SYA_NUM_DIAG;
    localparam int NR = `SYA_NUM_ROW;
    localparam int NC = `SYA_NUM_COL;

    typedef logic [`SYA_ADDR_WIDTH-1:0] addr_t;

    logic      clk;
    logic      rst_n;
    logic      cfg_vld;
    logic      cfg_rdy;
    sya_cfg_t  cfg_info;
    addr_t     act_rd_addr;
    addr_t     wgt_rd_addr;
    logic      addr_vld;
    logic      act_addr_rdy;
    logic      wgt_addr_rdy;
    act_vec_t  act_rd_dat;
    wgt_vec_t  wgt_rd_dat;
    logic      rd_dat_vld;
    ofm_word_t ofm_wr_dat;
    addr_t     ofm_wr_addr;
    logic      ofm_wr_vld;
    logic      ofm_wr_rdy;
    logic      out_stall;

    sya_cfg_t cur_cfg;
    string    cur_test;
    bit       job_on;
    bit       hung;
    int       wr_idx;
    int       issue_idx;
    int       wr_total;
    int       issue_total;
    int       errors;
    int       tests_run;
    int       tests_failed;

    sya_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_vld      (cfg_vld),
        .cfg_rdy      (cfg_rdy),
        .cfg_info     (cfg_info),
        .act_rd_addr  (act_rd_addr),
        .wgt_rd_addr  (wgt_rd_addr),
        .addr_vld     (addr_vld),
        .act_addr_rdy (act_addr_rdy),
        .wgt_addr_rdy (wgt_addr_rdy),
        .act_rd_dat   (act_rd_dat),
        .wgt_rd_dat   (wgt_rd_dat),
        .rd_dat_vld   (rd_dat_vld),
        .ofm_wr_dat   (ofm_wr_dat),
        .ofm_wr_addr  (ofm_wr_addr),
        .ofm_wr_vld   (ofm_wr_vld),
        .ofm_wr_rdy   (ofm_wr_rdy)
    );

    tb_sya_glb glb0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .act_rd_addr  (act_rd_addr),
        .wgt_rd_addr  (wgt_rd_addr),
        .addr_vld     (addr_vld),
        .act_addr_rdy (act_addr_rdy),
        .wgt_addr_rdy (wgt_addr_rdy),
        .act_rd_dat   (act_rd_dat),
        .wgt_rd_dat   (wgt_rd_dat),
        .rd_dat_vld   (rd_dat_vld),
        .out_stall    (out_stall),
        .ofm_wr_rdy   (ofm_wr_rdy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ==================================================
    // Reference model
    // ==================================================
    // Group number within the job to tile and group indices
    function automatic void job_pos(sya_cfg_t c, int g, output int ti, output int tf,
                                    output int grp);
        int t;
        grp = g % int'(c.num_grp);
        t = g / int'(c.num_grp);
        if (c.lop_ord == LOOP_IFM_OUTER) begin
            tf = t % int'(c.num_til_flt);
            ti = t / int'(c.num_til_flt);
        end else begin
            ti = t % int'(c.num_til_ifm);
            tf = t / int'(c.num_til_ifm);
        end
    endfunction

    function automatic addr_t read_addr(sya_cfg_t c, addr_t base, int til, int grp, int chn);
        int a;
        a = int'(base) + int'(c.num_chn) * int'(c.num_grp) * til + int'(c.num_chn) * grp + chn;
        return addr_t'(a);
    endfunction

    function automatic ofm_word_t ref_word(sya_cfg_t c, int idx);
        ofm_word_t w;
        int g;
        int d;
        int ti;
        int tf;
        int grp;
        int col;
        int p;
        int q;
        addr_t aa;
        addr_t wa;
        w = '0;
        g = idx / ND;
        d = idx % ND;
        job_pos(c, g, ti, tf, grp);
        for (int r = 0; r < NR; r++) begin
            col = d - r;
            if (col >= 0 && col < NC) begin
                p = 0;
                for (int ch = 0; ch < int'(c.num_chn); ch++) begin
                    aa = read_addr(c, c.act_base, ti, grp, ch);
                    wa = read_addr(c, c.wgt_base, tf, grp, ch);
                    p += int'(glb0.act_mem[aa][r]) * int'(glb0.wgt_mem[wa][col]);
                end
                // ReLU, then 8 bits from the shift position plus zero point
                if (p < 0) begin
                    w[r] = '0;
                end else begin
                    q = (c.shift >= 32) ? 0 : (p >> c.shift);
                    w[r] = 8'(q) + c.zp;
                end
            end
        end
        return w;
    endfunction

    function automatic sya_cfg_t make_cfg(addr_t ofm_base, addr_t act_base, addr_t wgt_base,
                                          int nti, int ntf, int ngrp, int nchn,
                                          int shift, int zp, loop_ord_t lop);
        sya_cfg_t c;
        c.ofm_base    = ofm_base;
        c.act_base    = act_base;
        c.wgt_base    = wgt_base;
        c.num_til_ifm = nti;
        c.num_til_flt = ntf;
        c.num_grp     = ngrp;
        c.num_chn     = nchn;
        c.shift       = shift;
        c.zp          = zp;
        c.lop_ord     = lop;
        return c;
    endfunction

    // ==================================================
    // Compare tasks
    // ==================================================
    task automatic compare_word(string name, ofm_word_t exp, ofm_word_t got);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, got);
        end
    endtask

    task automatic compare_addr(string name, addr_t exp, addr_t got);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, exp, got);
        end
    endtask

    task automatic compare_bit(string name, logic exp, logic got);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: expected %b, actual %b", name, exp, got);
        end
    endtask

    // Issued read pairs against the loop order
    always @(posedge clk) begin
        int g;
        int ti;
        int tf;
        int grp;
        int ch;
        if (job_on && addr_vld && act_addr_rdy && wgt_addr_rdy) begin
            if (issue_idx >= issue_total) begin
                errors++;
                $display("%s: a read pair was issued after the last one", cur_test);
            end else begin
                ch = issue_idx % int'(cur_cfg.num_chn);
                g = issue_idx / int'(cur_cfg.num_chn);
                job_pos(cur_cfg, g, ti, tf, grp);
                compare_addr($sformatf("%s act_rd_addr %0d", cur_test, issue_idx),
                             read_addr(cur_cfg, cur_cfg.act_base, ti, grp, ch), act_rd_addr);
                compare_addr($sformatf("%s wgt_rd_addr %0d", cur_test, issue_idx),
                             read_addr(cur_cfg, cur_cfg.wgt_base, tf, grp, ch), wgt_rd_addr);
            end
            issue_idx <= issue_idx + 1;
        end
    end

    // Accepted output writes
    always @(posedge clk) begin
        if (ofm_wr_vld && ofm_wr_rdy) begin
            if (!job_on || wr_idx >= wr_total) begin
                errors++;
                $display("%s: unexpected output write at address %h", cur_test, ofm_wr_addr);
            end else begin
                compare_addr($sformatf("%s ofm_wr_addr %0d", cur_test, wr_idx),
                             addr_t'(int'(cur_cfg.ofm_base) + wr_idx), ofm_wr_addr);
                compare_word($sformatf("%s ofm_wr_dat %0d", cur_test, wr_idx),
                             ref_word(cur_cfg, wr_idx), ofm_wr_dat);
            end
            wr_idx <= wr_idx + 1;
        end
    end

    // ==================================================
    // Test sequencing
    // ==================================================
    task automatic report_test(string name, int start_err);
        tests_run++;
        if (errors != start_err) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - start_err);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic report_hang(string name, string what);
        hung = 1'b1;
        tests_run++;
        tests_failed++;
        $display("test %s: timed out waiting for %s", name, what);
    endtask

    task automatic run_job(string name, sya_cfg_t c);
        int n;
        int start_err;
        bit seen;
        if (hung) begin
            return;
        end
        start_err   = errors;
        cur_test    = name;
        cur_cfg     = c;
        issue_total = int'(c.num_til_ifm) * int'(c.num_til_flt) * int'(c.num_grp)
                    * int'(c.num_chn);
        wr_total    = int'(c.num_til_ifm) * int'(c.num_til_flt) * int'(c.num_grp) * ND;
        issue_idx <= 0;
        wr_idx    <= 0;
        job_on      = 1'b1;
        cfg_info <= c;
        cfg_vld  <= 1'b1;
        seen = 1'b0;
        for (n = 0; n < 200 && !seen; n++) begin
            @(posedge clk);
            seen = cfg_vld && cfg_rdy;
        end
        cfg_vld <= 1'b0;
        if (!seen) begin
            report_hang(name, "the configuration to be accepted");
            return;
        end
        @(posedge clk);
        compare_bit({name, " cfg_rdy after accept"}, 1'b0, cfg_rdy);
        compare_bit({name, " addr_vld after accept"}, 1'b1, addr_vld);
        seen = 1'b0;
        for (n = 0; n < 20000 && !seen; n++) begin
            @(posedge clk);
            seen = (wr_idx == wr_total) && cfg_rdy;
        end
        if (!seen) begin
            report_hang(name, "all output words and the return to idle");
            return;
        end
        if (issue_idx != issue_total) begin
            errors++;
            $display("%s: %0d read pairs issued, %0d expected", name, issue_idx, issue_total);
        end
        job_on = 1'b0;
        report_test(name, start_err);
    endtask

    initial begin
        int start_err;
        rst_n        = 1'b0;
        cfg_vld      = 1'b0;
        cfg_info     = '0;
        out_stall    = 1'b0;
        job_on       = 1'b0;
        hung         = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        cur_test     = "reset_state";
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
        end
        rst_n <= 1'b1;
        @(posedge clk);
        start_err = errors;
        compare_bit("reset_state cfg_rdy", 1'b1, cfg_rdy);
        compare_bit("reset_state addr_vld", 1'b0, addr_vld);
        compare_bit("reset_state ofm_wr_vld", 1'b0, ofm_wr_vld);
        report_test("reset_state", start_err);

        run_job("one_group", make_cfg(16'h0100, 16'h0010, 16'h0200, 1, 1, 1, 5, 4, 0,
                                      LOOP_IFM_OUTER));
        run_job("tiles_ifm_outer", make_cfg(16'h0300, 16'h0400, 16'h0800, 2, 2, 2, 3, 5, 0,
                                            LOOP_IFM_OUTER));
        run_job("tiles_flt_outer", make_cfg(16'h0500, 16'h0400, 16'h0800, 2, 2, 2, 3, 5, 0,
                                            LOOP_FLT_OUTER));
        run_job("requant", make_cfg(16'h0600, 16'h1000, 16'h2000, 1, 1, 2, 8, 6, 8'h50,
                                    LOOP_IFM_OUTER));
        out_stall <= 1'b1;
        run_job("output_stalls", make_cfg(16'h0700, 16'h3000, 16'h4000, 2, 1, 2, 4, 3, 8'h11,
                                          LOOP_FLT_OUTER));
        run_job("second_cfg", make_cfg(16'hfff0, 16'h5000, 16'h6000, 1, 2, 1, 6, 2, 8'h03,
                                       LOOP_IFM_OUTER));

        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && !hung) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== test/tb_sya_glb.sv ====
`include "sya_settings.svh"

module tb_sya_glb
    import sya_data_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`SYA_ADDR_WIDTH-1:0] act_rd_addr,
    input  logic [`SYA_ADDR_WIDTH-1:0] wgt_rd_addr,
    input  logic                       addr_vld,
    output logic                       act_addr_rdy,
    output logic                       wgt_addr_rdy,
    output act_vec_t                   act_rd_dat,
    output wgt_vec_t                   wgt_rd_dat,
    output logic                       rd_dat_vld,
    input  logic                       out_stall,
    output logic                       ofm_wr_rdy
);

    timeunit 1ns;
    timeprecision 1ps;

    int seed;
    act_vec_t act_mem [65536];
    wgt_vec_t wgt_mem [65536];
    logic [`SYA_ADDR_WIDTH-1:0] act_q [$];
    logic [`SYA_ADDR_WIDTH-1:0] wgt_q [$];

    // Every buffer word gets its own random value
    initial begin
        seed = 32'h6b71;
        for (int i = 0; i < 65536; i++) begin
            act_mem[i] = $random(seed);
            wgt_mem[i] = $random(seed);
        end
    end

    // ==================================================
    // Read port with stalls and in-order return
    // ==================================================
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            act_addr_rdy <= 1'b0;
            wgt_addr_rdy <= 1'b0;
            act_rd_dat   <= '0;
            wgt_rd_dat   <= '0;
            rd_dat_vld   <= 1'b0;
            ofm_wr_rdy   <= 1'b0;
            act_q.delete();
            wgt_q.delete();
        end else begin
            act_addr_rdy <= ($random(seed) & 3) != 0;
            wgt_addr_rdy <= ($random(seed) & 3) != 0;
            if (out_stall) begin
                ofm_wr_rdy <= ($random(seed) & 1) != 0;
            end else begin
                ofm_wr_rdy <= 1'b1;
            end
            rd_dat_vld <= 1'b0;
            if (act_q.size() > 0 && ($random(seed) & 1) != 0) begin
                rd_dat_vld <= 1'b1;
                act_rd_dat <= act_mem[act_q.pop_front()];
                wgt_rd_dat <= wgt_mem[wgt_q.pop_front()];
            end
            if (addr_vld && act_addr_rdy && wgt_addr_rdy) begin
                act_q.push_back(act_rd_addr);
                wgt_q.push_back(wgt_rd_addr);
            end
        end
    end

endmodule

// ==== verilog/sya_top.sv ====
`include "sya_settings.svh"

module sya_top
    import sya_cfg_pkg::*;
    import sya_data_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cfg_vld,
    output logic                       cfg_rdy,
    input  sya_cfg_t                   cfg_info,
    output logic [`SYA_ADDR_WIDTH-1:0] act_rd_addr,
    output logic [`SYA_ADDR_WIDTH-1:0] wgt_rd_addr,
    output logic                       addr_vld,
    input  logic                       act_addr_rdy,
    input  logic                       wgt_addr_rdy,
    input  act_vec_t                   act_rd_dat,
    input  wgt_vec_t                   wgt_rd_dat,
    input  logic                       rd_dat_vld,
    output ofm_word_t                  ofm_wr_dat,
    output logic [`SYA_ADDR_WIDTH-1:0] ofm_wr_addr,
    output logic                       ofm_wr_vld,
    input  logic                       ofm_wr_rdy
);

    sya_cfg_t   cfg;
    logic       rd_last;
    logic       drain_done;
    logic       res_vld;
    psum_grid_t res;
    act_item_t  act_in [`SYA_NUM_ROW];
    wgt_item_t  wgt_in [`SYA_NUM_COL];
    act_item_t  act_sk [`SYA_NUM_ROW];
    wgt_item_t  wgt_sk [`SYA_NUM_COL];

    sya_loop_ctrl u_loop_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_vld      (cfg_vld),
        .cfg_rdy      (cfg_rdy),
        .cfg_info     (cfg_info),
        .act_rd_addr  (act_rd_addr),
        .wgt_rd_addr  (wgt_rd_addr),
        .addr_vld     (addr_vld),
        .act_addr_rdy (act_addr_rdy),
        .wgt_addr_rdy (wgt_addr_rdy),
        .rd_dat_vld   (rd_dat_vld),
        .rd_last      (rd_last),
        .drain_done   (drain_done),
        .cfg          (cfg)
    );

    // ==================================================
    // Returned data into items, then skew
    // ==================================================
    for (genvar r = 0; r < `SYA_NUM_ROW; r++) begin : g_act
        assign act_in[r] = '{vld: rd_dat_vld, chn_last: rd_last, dat: act_rd_dat[r]};
    end

    for (genvar c = 0; c < `SYA_NUM_COL; c++) begin : g_wgt
        assign wgt_in[c] = '{vld: rd_dat_vld, chn_last: rd_last, dat: wgt_rd_dat[c]};
    end

    sya_skew_line #(.item_t(act_item_t), .NUM_LANE(`SYA_NUM_ROW)) u_skew_act (
        .clk   (clk),
        .rst_n (rst_n),
        .din   (act_in),
        .dout  (act_sk)
    );

    sya_skew_line #(.item_t(wgt_item_t), .NUM_LANE(`SYA_NUM_COL)) u_skew_wgt (
        .clk   (clk),
        .rst_n (rst_n),
        .din   (wgt_in),
        .dout  (wgt_sk)
    );

    sya_pe_array u_pe_array (
        .clk     (clk),
        .rst_n   (rst_n),
        .act_w   (act_sk),
        .wgt_n   (wgt_sk),
        .res     (res),
        .res_vld (res_vld)
    );

    sya_drain u_drain (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .res         (res),
        .res_vld     (res_vld),
        .ofm_wr_dat  (ofm_wr_dat),
        .ofm_wr_addr (ofm_wr_addr),
        .ofm_wr_vld  (ofm_wr_vld),
        .ofm_wr_rdy  (ofm_wr_rdy),
        .drain_done  (drain_done)
    );

endmodule

// ==== verilog/sya_drain.sv ====
`include "sya_settings.svh"

module sya_drain
    import sya_cfg_pkg::*;
    import sya_data_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  sya_cfg_t                   cfg,
    input  psum_grid_t                 res,
    input  logic                       res_vld,
    output ofm_word_t                  ofm_wr_dat,
    output logic [`SYA_ADDR_WIDTH-1:0] ofm_wr_addr,
    output logic                       ofm_wr_vld,
    input  logic                       ofm_wr_rdy,
    output logic                       drain_done
);

    localparam int DIAG_W = $clog2(`SYA_NUM_DIAG);
    localparam int JOB_W = 3 * `SYA_IDX_WIDTH;

    logic busy;
    logic [DIAG_W-1:0] diag;
    logic [`SYA_ADDR_WIDTH-1:0] offs;
    logic [JOB_W-1:0] grp_done;
    logic [JOB_W-1:0] job_grps;
    logic wr_fire;
    logic diag_last;

    // ReLU, then take 8 bits at the shift position and add zero point
    function automatic logic [`SYA_ACT_WIDTH-1:0] requant(
        psum_t p,
        logic [`SYA_ACT_WIDTH-1:0] shift,
        logic [`SYA_ACT_WIDTH-1:0] zp
    );
        psum_t s;
        if (p < 0) begin
            return '0;
        end
        s = p >>> shift;
        return s[`SYA_ACT_WIDTH-1:0] + zp;
    endfunction

    // ==================================================
    // Diagonal select
    // ==================================================
    always_comb begin
        ofm_wr_dat = '0;
        for (int r = 0; r < `SYA_NUM_ROW; r++) begin
            for (int c = 0; c < `SYA_NUM_COL; c++) begin
                if (r + c == int'(diag)) begin
                    ofm_wr_dat[r] = requant(res[r][c], cfg.shift, cfg.zp);
                end
            end
        end
    end

    assign ofm_wr_vld  = busy;
    assign ofm_wr_addr = cfg.ofm_base + offs;
    assign wr_fire     = busy & ofm_wr_rdy;
    assign diag_last   = (diag == DIAG_W'(`SYA_NUM_DIAG - 1));
    assign drain_done  = wr_fire & diag_last;

    // Groups in the whole job, so the address restarts for the next one
    assign job_grps = cfg.num_til_ifm * cfg.num_til_flt * cfg.num_grp;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            diag     <= '0;
            offs     <= '0;
            grp_done <= '0;
        end else begin
            if (res_vld) begin
                busy <= 1'b1;
            end else if (drain_done) begin
                busy <= 1'b0;
            end
            if (wr_fire) begin
                diag <= diag_last ? '0 : diag + 1'b1;
                offs <= offs + 1'b1;
            end
            if (drain_done) begin
                if (grp_done == job_grps - 1'b1) begin
                    grp_done <= '0;
                    offs     <= '0;
                end else begin
                    grp_done <= grp_done + 1'b1;
                end
            end
        end
    end

endmodule

// ==== verilog/sya_pe_array.sv ====
`include "sya_settings.svh"

module sya_pe_array
    import sya_data_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  act_item_t  act_w [`SYA_NUM_ROW],
    input  wgt_item_t  wgt_n [`SYA_NUM_COL],
    output psum_grid_t res,
    output logic       res_vld
);

    localparam int NR = `SYA_NUM_ROW;
    localparam int NC = `SYA_NUM_COL;

    act_item_t a_in [NR][NC];
    wgt_item_t w_in [NR][NC];
    act_item_t a_q  [NR][NC];
    wgt_item_t w_q  [NR][NC];
    psum_t     acc  [NR][NC];
    psum_t     sum  [NR][NC];
    logic      hit  [NR][NC];
    logic      cap  [NR][NC];

    // ==================================================
    // Cell inputs from the west edge or the neighbour
    // ==================================================
    for (genvar r = 0; r < NR; r++) begin : g_row
        for (genvar c = 0; c < NC; c++) begin : g_col
            if (c == 0) begin : g_west
                assign a_in[r][c] = act_w[r];
            end else begin : g_east
                assign a_in[r][c] = a_q[r][c-1];
            end
            if (r == 0) begin : g_north
                assign w_in[r][c] = wgt_n[c];
            end else begin : g_south
                assign w_in[r][c] = w_q[r-1][c];
            end
            assign hit[r][c] = a_in[r][c].vld & w_in[r][c].vld;
            assign cap[r][c] = hit[r][c] & a_in[r][c].chn_last;
            assign sum[r][c] = acc[r][c] + a_in[r][c].dat * w_in[r][c].dat;
        end
    end

    // ==================================================
    // Forwarding and accumulation
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < NR; r++) begin
                for (int c = 0; c < NC; c++) begin
                    a_q[r][c] <= '0;
                    w_q[r][c] <= '0;
                    acc[r][c] <= '0;
                end
            end
            res_vld <= 1'b0;
        end else begin
            for (int r = 0; r < NR; r++) begin
                for (int c = 0; c < NC; c++) begin
                    a_q[r][c] <= a_in[r][c];
                    w_q[r][c] <= w_in[r][c];
                    // Last channel empties the accumulator for the next group
                    if (hit[r][c]) begin
                        acc[r][c] <= cap[r][c] ? '0 : sum[r][c];
                    end
                end
            end
            res_vld <= cap[NR-1][NC-1];
        end
    end

    always_ff @(posedge clk) begin
        for (int r = 0; r < NR; r++) begin
            for (int c = 0; c < NC; c++) begin
                if (cap[r][c]) begin
                    res[r][c] <= sum[r][c];
                end
            end
        end
    end

endmodule

// ==== verilog/sya_skew_line.sv ====
module sya_skew_line #(
    parameter type item_t = logic,
    parameter int  NUM_LANE = 4
) (
    input  logic  clk,
    input  logic  rst_n,
    input  item_t din  [NUM_LANE],
    output item_t dout [NUM_LANE]
);

    // Lane k sits k stages deep, lane 0 goes straight through
    for (genvar k = 0; k < NUM_LANE; k++) begin : g_lane
        if (k == 0) begin : g_direct
            assign dout[k] = din[k];
        end else begin : g_delay
            item_t pipe [k];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    for (int i = 0; i < k; i++) begin
                        pipe[i] <= '0;
                    end
                end else begin
                    pipe[0] <= din[k];
                    for (int i = 1; i < k; i++) begin
                        pipe[i] <= pipe[i-1];
                    end
                end
            end

            assign dout[k] = pipe[k-1];
        end
    end

endmodule

// ==== verilog/sya_loop_ctrl.sv ====
`include "sya_settings.svh"

module sya_loop_ctrl
    import sya_cfg_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       cfg_vld,
    output logic                       cfg_rdy,
    input  sya_cfg_t                   cfg_info,
    output logic [`SYA_ADDR_WIDTH-1:0] act_rd_addr,
    output logic [`SYA_ADDR_WIDTH-1:0] wgt_rd_addr,
    output logic                       addr_vld,
    input  logic                       act_addr_rdy,
    input  logic                       wgt_addr_rdy,
    input  logic                       rd_dat_vld,
    output logic                       rd_last,
    input  logic                       drain_done,
    output sya_cfg_t                   cfg
);

    localparam int FLAG_DEPTH = 16;
    localparam int PTR_W = $clog2(FLAG_DEPTH);

    logic run;
    logic all_issued;
    logic [`SYA_CHN_WIDTH-1:0] chn;
    logic [`SYA_IDX_WIDTH-1:0] grp;
    logic [`SYA_IDX_WIDTH-1:0] til_ifm;
    logic [`SYA_IDX_WIDTH-1:0] til_flt;
    logic ovf_chn, ovf_grp, ovf_ifm, ovf_flt;
    logic inc_grp, inc_ifm, inc_flt;
    logic accept, fire, in_last, pending, job_last;
    logic flag_mem [FLAG_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0] flag_cnt;

    assign cfg_rdy = ~run;
    assign accept  = cfg_vld & cfg_rdy;

    // ==================================================
    // Loop counters and carries
    // ==================================================
    assign ovf_chn = (chn == cfg.num_chn - 1'b1);
    assign ovf_grp = (grp == cfg.num_grp - 1'b1);
    assign ovf_ifm = (til_ifm == cfg.num_til_ifm - 1'b1);
    assign ovf_flt = (til_flt == cfg.num_til_flt - 1'b1);
    assign in_last = ovf_chn;

    // Last channel waits until the previous group has drained
    assign addr_vld = run & ~all_issued & ~(in_last & pending) & (flag_cnt != FLAG_DEPTH);
    assign fire     = addr_vld & act_addr_rdy & wgt_addr_rdy;

    always_comb begin
        inc_grp = fire & ovf_chn;
        if (cfg.lop_ord == LOOP_IFM_OUTER) begin
            inc_flt = inc_grp & ovf_grp;
            inc_ifm = inc_flt & ovf_flt;
        end else begin
            inc_ifm = inc_grp & ovf_grp;
            inc_flt = inc_ifm & ovf_ifm;
        end
    end

    assign job_last = inc_grp & ovf_grp & ovf_flt & ovf_ifm;

    assign act_rd_addr = cfg.act_base + cfg.num_chn * cfg.num_grp * til_ifm
                       + cfg.num_chn * grp + chn;
    assign wgt_rd_addr = cfg.wgt_base + cfg.num_chn * cfg.num_grp * til_flt
                       + cfg.num_chn * grp + chn;

    always_ff @(posedge clk) begin
        if (accept) begin
            cfg <= cfg_info;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run        <= 1'b0;
            all_issued <= 1'b0;
            chn        <= '0;
            grp        <= '0;
            til_ifm    <= '0;
            til_flt    <= '0;
        end else if (accept) begin
            run        <= 1'b1;
            all_issued <= 1'b0;
            chn        <= '0;
            grp        <= '0;
            til_ifm    <= '0;
            til_flt    <= '0;
        end else begin
            if (fire) begin
                chn <= ovf_chn ? '0 : chn + 1'b1;
            end
            if (inc_grp) begin
                grp <= ovf_grp ? '0 : grp + 1'b1;
            end
            if (inc_ifm) begin
                til_ifm <= ovf_ifm ? '0 : til_ifm + 1'b1;
            end
            if (inc_flt) begin
                til_flt <= ovf_flt ? '0 : til_flt + 1'b1;
            end
            if (job_last) begin
                all_issued <= 1'b1;
            end
            // Back to idle once the final group is written out
            if (drain_done && all_issued) begin
                run <= 1'b0;
            end
        end
    end

    // Last channel issued, results not yet drained
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (fire && in_last) begin
            pending <= 1'b1;
        end else if (drain_done) begin
            pending <= 1'b0;
        end
    end

    // ==================================================
    // chn_last flags for returned data, in issue order
    // ==================================================
    always_ff @(posedge clk) begin
        if (fire) begin
            flag_mem[wr_ptr] <= in_last;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            flag_cnt <= '0;
        end else begin
            if (fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_dat_vld) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({fire, rd_dat_vld})
                2'b10:   flag_cnt <= flag_cnt + 1'b1;
                2'b01:   flag_cnt <= flag_cnt - 1'b1;
                default: flag_cnt <= flag_cnt;
            endcase
        end
    end

    assign rd_last = flag_mem[rd_ptr];

endmodule

// ==== verilog/sya_data_pkg.sv ====
`include "sya_settings.svh"

package sya_data_pkg;

    // ==================================================
    // Lanes and vectors from the global buffer
    // ==================================================
    typedef logic signed [`SYA_ACT_WIDTH-1:0] act_lane_t;
    typedef logic signed [`SYA_WGT_WIDTH-1:0] wgt_lane_t;

    typedef act_lane_t [`SYA_NUM_ROW-1:0] act_vec_t;
    typedef wgt_lane_t [`SYA_NUM_COL-1:0] wgt_vec_t;

    // ==================================================
    // Results
    // ==================================================
    typedef logic signed [`SYA_PSUM_WIDTH-1:0] psum_t;
    typedef psum_t [`SYA_NUM_ROW-1:0][`SYA_NUM_COL-1:0] psum_grid_t;

    // Requantized lanes are unsigned
    typedef logic [`SYA_NUM_ROW-1:0][`SYA_ACT_WIDTH-1:0] ofm_word_t;

    // Per-lane items travelling through the skew lines and array
    typedef struct packed {
        logic      vld;
        logic      chn_last;
        act_lane_t dat;
    } act_item_t;

    typedef struct packed {
        logic      vld;
        logic      chn_last;
        wgt_lane_t dat;
    } wgt_item_t;

endpackage

// ==== verilog/sya_cfg_pkg.sv ====
`include "sya_settings.svh"

package sya_cfg_pkg;

    // Which tile index runs in the outer loop
    typedef enum logic {
        LOOP_IFM_OUTER = 1'b0,
        LOOP_FLT_OUTER = 1'b1
    } loop_ord_t;

    // ==================================================
    // Configuration word, 129 bits, MSB first
    // ==================================================
    typedef struct packed {
        logic [`SYA_ADDR_WIDTH-1:0] ofm_base;
        logic [`SYA_ADDR_WIDTH-1:0] act_base;
        logic [`SYA_ADDR_WIDTH-1:0] wgt_base;
        logic [`SYA_IDX_WIDTH-1:0]  num_til_ifm;
        logic [`SYA_IDX_WIDTH-1:0]  num_til_flt;
        logic [`SYA_IDX_WIDTH-1:0]  num_grp;
        logic [`SYA_CHN_WIDTH-1:0]  num_chn;
        // Requantization
        logic [`SYA_ACT_WIDTH-1:0]  shift;
        logic [`SYA_ACT_WIDTH-1:0]  zp;
        loop_ord_t                  lop_ord;
    } sya_cfg_t;

endpackage

// ==== verilog/sya_settings.svh ====
`ifndef SYA_SETTINGS_SVH
`define SYA_SETTINGS_SVH

// ==================================================
// Data widths
// ==================================================
`define SYA_ACT_WIDTH 8
`define SYA_WGT_WIDTH 8
`define SYA_CHN_WIDTH 16
`define SYA_IDX_WIDTH 16
`define SYA_ADDR_WIDTH 16

// ==================================================
// Array geometry
// ==================================================
`define SYA_NUM_ROW 4
`define SYA_NUM_COL 4

// One output word per anti-diagonal
`define SYA_NUM_DIAG (`SYA_NUM_ROW + `SYA_NUM_COL - 1)

// Full product plus channel growth
`define SYA_PSUM_WIDTH (`SYA_ACT_WIDTH + `SYA_WGT_WIDTH + `SYA_CHN_WIDTH)

`endif
